//--- list.f
hw/uart_pkg.sv
hw/uart_cmd_tx.sv
hw/uart_byte_rx.sv
hw/uart_top.sv
sim/uart_properties.sv
sim/uart_tb.sv

//--- Makefile
TOP = uart_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

lint:
	verilator --lint-only -Wall --timing --assert -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- sim/uart_tb.sv
`timescale 1ns/1ps

module uart_tb;

   localparam int n_cmds = 12;
   localparam int n_direct = 6;
   localparam int timeout_cycles =
      (n_cmds + n_direct + 4) * uart_pkg::cmd_bits * uart_pkg::clks_per_bit;

   logic clk;
   logic rst_n;
   uart_pkg::cmd_t cmd_in;
   logic cmd_vld;
   logic cmd_rdy;
   logic tx;
   logic rx;
   uart_pkg::byte_t read_data;
   logic read_rdy;
   logic parity_err;
   logic frame_err;

   logic loopback;            // rx follows tx when set.
   logic rx_drive;            // bit-banged line for direct frames.
   logic [31:0] lcg_state;
   logic [9:0] exp_q[$];      // {frame_err, parity_err, data}.
   int value_errs = 0;
   int other_errs = 0;

   assign rx = loopback ? tx : rx_drive;

   uart_top i_uart_top (
      .clk        (clk),
      .rst_n      (rst_n),
      .cmd_in     (cmd_in),
      .cmd_vld    (cmd_vld),
      .cmd_rdy    (cmd_rdy),
      .tx         (tx),
      .rx         (rx),
      .read_data  (read_data),
      .read_rdy   (read_rdy),
      .parity_err (parity_err),
      .frame_err  (frame_err)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // odd parity: the bit is set when the byte holds an even number of ones.
   function automatic logic odd_parity_bit(input uart_pkg::byte_t b);
      return ($countones(b) % 2) == 0;
   endfunction

   // holds cmd_vld until the DUT takes the command.
   task automatic send_cmd(input uart_pkg::cmd_t c);
      cmd_in  = c;
      cmd_vld = 1'b1;
      exp_q.push_back({2'b00, c[15:8]});
      exp_q.push_back({2'b00, c[7:0]});
      while (!cmd_rdy) @(negedge clk);
      @(negedge clk);
      cmd_vld = 1'b0;
   endtask

   // a valid pulse while the transmitter is busy, must be dropped.
   task automatic poke_while_busy(input uart_pkg::cmd_t c);
      repeat (10) @(negedge clk);
      cmd_in  = c;
      cmd_vld = 1'b1;
      @(negedge clk);
      cmd_vld = 1'b0;
   endtask

   task automatic send_frame(input uart_pkg::byte_t d, input logic par, input logic stp);
      logic [10:0] bits;
      bits = {stp, par, d, 1'b0};
      exp_q.push_back({!stp, par != odd_parity_bit(d), d});
      repeat (uart_pkg::frame_bits) begin
         rx_drive = bits[0];
         repeat (uart_pkg::clks_per_bit) @(negedge clk);
         bits = bits >> 1;
      end
      rx_drive = 1'b1;   // idle gap before the next frame.
      repeat (2 * uart_pkg::clks_per_bit) @(negedge clk);
   endtask

   task automatic direct_frame(input logic par_bad, input logic stop_bad);
      uart_pkg::byte_t b;
      lcg_state = lcg_next(lcg_state);
      b = lcg_state[31:24];
      send_frame(b, odd_parity_bit(b) ^ par_bad, !stop_bad);
   endtask

   task automatic wait_drain;
      while (exp_q.size() != 0) @(negedge clk);
      repeat (uart_pkg::clks_per_bit) @(negedge clk);
   endtask

   // scoreboard, sampled away from the active clock edge.
   initial begin
      logic [9:0] entry;
      forever begin
         @(negedge clk);
         if (rst_n && read_rdy) begin
            if (exp_q.size() == 0) begin
               other_errs++;
               $display("byte %h received at %0t while no byte was expected", read_data, $time);
            end else begin
               entry = exp_q.pop_front();
               assert (read_data == entry[7:0]) else begin
                  value_errs++;
                  $display("FAIL %0t read_data expected %h got %h",
                           $time, entry[7:0], read_data);
               end
               assert (parity_err == entry[8]) else begin
                  value_errs++;
                  $display("FAIL %0t parity_err expected %b got %b",
                           $time, entry[8], parity_err);
               end
               assert (frame_err == entry[9]) else begin
                  value_errs++;
                  $display("FAIL %0t frame_err expected %b got %b",
                           $time, entry[9], frame_err);
               end
            end
         end
      end
   end

   initial begin
      repeat (timeout_cycles) @(posedge clk);
      $display("timeout, the run did not finish within %0d cycles", timeout_cycles);
      $display("CHECKS FAILED");
      $finish;
   end

   initial begin
      uart_pkg::cmd_t cmd;
      rst_n     = 1'b0;
      cmd_in    = '0;
      cmd_vld   = 1'b0;
      loopback  = 1'b1;
      rx_drive  = 1'b1;
      lcg_state = 32'd53;
      repeat (2) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);

      // loopback, commands back to back.
      for (int n = 0; n < n_cmds; n++) begin
         lcg_state = lcg_next(lcg_state);
         cmd = lcg_state[31:16];
         send_cmd(cmd);
         if (n % 3 == 1) begin
            poke_while_busy(~cmd);
         end
      end
      wait_drain();
      loopback = 1'b0;

      // direct frames: parity errors, stop errors, clean frames after a bad stop.
      direct_frame(1'b1, 1'b0);
      direct_frame(1'b1, 1'b0);
      direct_frame(1'b0, 1'b1);
      direct_frame(1'b0, 1'b0);
      direct_frame(1'b1, 1'b1);
      direct_frame(1'b0, 1'b0);
      wait_drain();

      // quiet time to catch stray strobes.
      repeat (uart_pkg::cmd_bits * uart_pkg::clks_per_bit) @(negedge clk);
      if (exp_q.size() != 0) begin
         other_errs++;
         $display("%0d expected bytes were never received", exp_q.size());
      end

      $display("errors: %0d value, %0d other", value_errs, other_errs);
      if (value_errs + other_errs == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

//--- sim/uart_properties.sv
`timescale 1ns/1ps

module uart_properties (
   input logic             clk,
   input logic             rst_n,
   input logic             cmd_vld,
   input logic             cmd_rdy,
   input logic             tx,
   input uart_pkg::byte_t  read_data,
   input logic             read_rdy,
   input logic             parity_err,
   input logic             frame_err
);

   localparam int busy_cycles = uart_pkg::cmd_bits * uart_pkg::clks_per_bit;

   int busy_cnt;   // sampled cycles with cmd_rdy low.

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy_cnt <= 0;
      end else if (!cmd_rdy) begin
         busy_cnt <= busy_cnt + 1;
      end else begin
         busy_cnt <= 0;
      end
   end

   reset_state_a: assert property (@(posedge clk)
      $rose(rst_n) |-> cmd_rdy && tx && !read_rdy && !parity_err && !frame_err &&
                       read_data == '0)
      else $error("outputs not in reset state after reset");

   accept_busy_a: assert property (@(posedge clk) disable iff (!rst_n)
      cmd_vld && cmd_rdy |=> !cmd_rdy)
      else $error("cmd_rdy still high after a command was accepted");

   busy_len_a: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(cmd_rdy) |-> busy_cnt == busy_cycles)
      else $error("cmd_rdy low for %0d cycles, %0d expected", busy_cnt, busy_cycles);

   busy_max_a: assert property (@(posedge clk) disable iff (!rst_n)
      !cmd_rdy |-> busy_cnt < busy_cycles)
      else $error("cmd_rdy low longer than %0d cycles", busy_cycles);

   tx_idle_a: assert property (@(posedge clk) disable iff (!rst_n)
      cmd_rdy |-> tx)
      else $error("tx low while the transmitter is idle");

   strobe_len_a: assert property (@(posedge clk) disable iff (!rst_n)
      read_rdy |=> !read_rdy)
      else $error("read_rdy high for more than one cycle");

   err_strobe_a: assert property (@(posedge clk) disable iff (!rst_n)
      parity_err || frame_err |-> read_rdy)
      else $error("error flag high without read_rdy");

endmodule

bind uart_top uart_properties i_uart_properties (
   .clk        (clk),
   .rst_n      (rst_n),
   .cmd_vld    (cmd_vld),
   .cmd_rdy    (cmd_rdy),
   .tx         (tx),
   .read_data  (read_data),
   .read_rdy   (read_rdy),
   .parity_err (parity_err),
   .frame_err  (frame_err)
);

//--- hw/uart_top.sv
`timescale 1ns/1ps

module uart_top (
   input  logic             clk,
   input  logic             rst_n,
   input  uart_pkg::cmd_t   cmd_in,
   input  logic             cmd_vld,
   output logic             cmd_rdy,
   output logic             tx,
   input  logic             rx,
   output uart_pkg::byte_t  read_data,
   output logic             read_rdy,
   output logic             parity_err,
   output logic             frame_err
);

   // command path out on tx.
   uart_cmd_tx i_cmd_tx (
      .clk     (clk),
      .rst_n   (rst_n),
      .cmd_in  (cmd_in),
      .cmd_vld (cmd_vld),
      .cmd_rdy (cmd_rdy),
      .tx      (tx)
   );

   // byte path in on rx, looped back outside if needed.
   uart_byte_rx i_byte_rx (
      .clk        (clk),
      .rst_n      (rst_n),
      .rx         (rx),
      .read_data  (read_data),
      .read_rdy   (read_rdy),
      .parity_err (parity_err),
      .frame_err  (frame_err)
   );

endmodule

//--- hw/uart_byte_rx.sv
`timescale 1ns/1ps

module uart_byte_rx (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             rx,
   output uart_pkg::byte_t  read_data,
   output logic             read_rdy,
   output logic             parity_err,
   output logic             frame_err
);

   typedef enum logic [2:0] {
      idle,
      start,
      data,
      parity,
      stop
   } rx_state_t;

   rx_state_t state;
   logic rx_meta;
   logic rx_sync;
   logic rx_prev;
   uart_pkg::baud_cnt_t baud_cnt;
   uart_pkg::bit_cnt_t bit_cnt;
   uart_pkg::byte_t shift_q;
   logic par_bit;
   logic half_done;
   logic bit_done;
   logic last_data;

   // two flops against metastability, a third for the start edge.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
         rx_prev <= 1'b1;
      end else begin
         rx_meta <= rx;
         rx_sync <= rx_meta;
         rx_prev <= rx_sync;
      end
   end

   assign half_done = (baud_cnt == uart_pkg::baud_cnt_t'(uart_pkg::clks_per_bit / 2 - 1));
   assign bit_done  = (baud_cnt == uart_pkg::baud_cnt_t'(uart_pkg::clks_per_bit - 1));
   // bit_cnt holds the index of the data bit being sampled.
   assign last_data = (bit_cnt == uart_pkg::bit_cnt_t'(uart_pkg::frame_bits - 4));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= idle;
         baud_cnt   <= '0;
         bit_cnt    <= '0;
         read_data  <= '0;
         read_rdy   <= 1'b0;
         parity_err <= 1'b0;
         frame_err  <= 1'b0;
      end else begin
         read_rdy   <= 1'b0;
         parity_err <= 1'b0;
         frame_err  <= 1'b0;
         case (state)
            idle: begin
               // a falling edge, so a low stop bit is not taken as a start.
               if (!rx_sync && rx_prev) begin
                  state    <= start;
                  baud_cnt <= '0;
               end
            end
            start: begin
               if (half_done) begin
                  baud_cnt <= '0;
                  bit_cnt  <= '0;
                  state    <= rx_sync ? idle : data;   // glitch, back to idle.
               end else begin
                  baud_cnt <= baud_cnt + 1'b1;
               end
            end
            data, parity: begin
               if (bit_done) begin
                  baud_cnt <= '0;
                  bit_cnt  <= bit_cnt + 1'b1;
                  if (state == parity) begin
                     state <= stop;
                  end else if (last_data) begin
                     state <= parity;
                  end
               end else begin
                  baud_cnt <= baud_cnt + 1'b1;
               end
            end
            stop: begin
               if (bit_done) begin
                  state      <= idle;
                  baud_cnt   <= '0;
                  read_rdy   <= 1'b1;
                  read_data  <= shift_q;
                  parity_err <= (par_bit != ~^shift_q);
                  frame_err  <= !rx_sync;
               end else begin
                  baud_cnt <= baud_cnt + 1'b1;
               end
            end
            default: begin
               state <= idle;
            end
         endcase
      end
   end

   // data arrives lsb first, so it enters at the top.
   always_ff @(posedge clk) begin
      if (state == data && bit_done) begin
         shift_q <= {rx_sync, shift_q[7:1]};
      end
      if (state == parity && bit_done) begin
         par_bit <= rx_sync;
      end
   end

endmodule

//--- hw/uart_cmd_tx.sv
`timescale 1ns/1ps

module uart_cmd_tx (
   input  logic            clk,
   input  logic            rst_n,
   input  uart_pkg::cmd_t  cmd_in,
   input  logic            cmd_vld,
   output logic            cmd_rdy,
   output logic            tx
);

   typedef enum logic {
      idle,
      send
   } tx_state_t;

   tx_state_t state;
   uart_pkg::baud_cnt_t baud_cnt;
   uart_pkg::bit_cnt_t bit_cnt;
   logic [uart_pkg::cmd_bits-1:0] image;
   logic [uart_pkg::cmd_bits-1:0] shift_q;
   logic accept;
   logic bit_done;
   logic last_bit;

   // one frame, lsb first on the wire: start, data, odd parity, stop.
   function automatic logic [uart_pkg::frame_bits-1:0] make_frame(input uart_pkg::byte_t b);
      make_frame = {1'b1, ~^b, b, 1'b0};
   endfunction

   // high byte frame sits in the low bits so it goes out first.
   assign image = {make_frame(cmd_in[7:0]), make_frame(cmd_in[15:8])};

   assign cmd_rdy  = (state == idle);
   assign accept   = cmd_vld && cmd_rdy;
   assign bit_done = (state == send) &&
                     (baud_cnt == uart_pkg::baud_cnt_t'(uart_pkg::clks_per_bit - 1));
   assign last_bit = (bit_cnt == uart_pkg::bit_cnt_t'(uart_pkg::cmd_bits - 1));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= idle;
         baud_cnt <= '0;
         bit_cnt  <= '0;
         tx       <= 1'b1;
      end else begin
         case (state)
            idle: begin
               if (accept) begin
                  state    <= send;
                  baud_cnt <= '0;
                  bit_cnt  <= '0;
                  tx       <= image[0];   // start bit of the high byte.
               end
            end
            send: begin
               if (bit_done) begin
                  baud_cnt <= '0;
                  if (last_bit) begin
                     state <= idle;
                     tx    <= 1'b1;   // line idles high.
                  end else begin
                     bit_cnt <= bit_cnt + 1'b1;
                     tx      <= shift_q[0];
                  end
               end else begin
                  baud_cnt <= baud_cnt + 1'b1;
               end
            end
            default: begin
               state <= idle;
               tx    <= 1'b1;
            end
         endcase
      end
   end

   // remaining bits of the command, next bit to send at bit 0.
   always_ff @(posedge clk) begin
      if (accept) begin
         shift_q <= {1'b1, image[uart_pkg::cmd_bits-1:1]};
      end else if (bit_done) begin
         shift_q <= {1'b1, shift_q[uart_pkg::cmd_bits-1:1]};
      end
   end

endmodule

//--- hw/uart_pkg.sv
package uart_pkg;

   // serial timing.
   localparam int clks_per_bit = 4;   // clock cycles per serial bit.

   // frame layout: start, 8 data bits lsb first, odd parity, stop.
   localparam int frame_bits = 11;
   localparam int cmd_bits = 2 * frame_bits;   // high byte frame, then low byte frame.

   // 16-bit register-access command.
   typedef logic [15:0] cmd_t;

   // one serial data byte.
   typedef logic [7:0] byte_t;

   // index of a bit within a command or a frame.
   typedef logic [4:0] bit_cnt_t;

   // clock count within one bit period.
   typedef logic [$clog2(clks_per_bit + 1) - 1:0] baud_cnt_t;

endpackage
